// ==== logic/alu_pkg.sv ====
package alu_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS_B,
		ALU_EQ
	} alu_op_e;

	typedef enum logic [1:0] {OP_A_REG, OP_A_ZERO, OP_A_PC} op_a_sel_e;

	typedef enum logic {OP_B_REG, OP_B_IMM} op_b_sel_e;

	typedef enum logic [1:0] {WB_ALU, WB_LSU, WB_PC4} wb_sel_e;

endpackage

// ==== logic/riscv_pkg.sv ====
package riscv_pkg;
	import alu_pkg::*;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  reg_idx_t;

	// Reset PC
	localparam addr_t BOOT_ADDRESS = 32'h0000_0000;

	// Major opcodes of the kept subset
	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
	localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
	localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
	localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
	localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

	typedef struct packed {
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		reg_idx_t   rd;
		logic       rf_we;
		alu_op_e    alu_op;
		op_a_sel_e  op_a_sel;
		op_b_sel_e  op_b_sel;
		wb_sel_e    wb_sel;
		logic       lsu_re;
		logic       lsu_we;
		logic       branch;
		// BNE when set, BEQ otherwise
		logic       branch_ne;
		logic       jump;
		logic       illegal;
		word_t      imm;
	} decoded_t;

endpackage

// ==== logic/lsu_if.sv ====
`timescale 1ns/100ps

interface lsu_if import riscv_pkg::*; ();

	// Request levels, held until done
	logic  re;
	logic  we;
	addr_t addr;
	word_t wdata;

	word_t rdata;
	logic  done;

	modport core (output re, output we, output addr, output wdata, input rdata, input done);

	modport unit (input re, input we, input addr, input wdata, output rdata, output done);

endinterface

// ==== logic/alu.sv ====
`timescale 1ns/100ps

module alu import alu_pkg::*, riscv_pkg::*;
(
	input  alu_op_e alu_op_i,
	input  word_t   operand_a_i,
	input  word_t   operand_b_i,
	output word_t   alu_result_o
);

	logic [4:0] shamt;

	assign shamt = operand_b_i[4:0];

	always_comb
	begin
		case (alu_op_i)
			ALU_ADD:    alu_result_o = operand_a_i + operand_b_i;
			ALU_SUB:    alu_result_o = operand_a_i - operand_b_i;
			ALU_AND:    alu_result_o = operand_a_i & operand_b_i;
			ALU_OR:     alu_result_o = operand_a_i | operand_b_i;
			ALU_XOR:    alu_result_o = operand_a_i ^ operand_b_i;
			ALU_SLT:    alu_result_o = {31'b0, $signed(operand_a_i) < $signed(operand_b_i)};
			ALU_SLL:    alu_result_o = operand_a_i << shamt;
			ALU_SRL:    alu_result_o = operand_a_i >> shamt;
			ALU_SRA:    alu_result_o = word_t'($signed(operand_a_i) >>> shamt);
			ALU_PASS_B: alu_result_o = operand_b_i;
			// Branch compare, bit 0 only
			ALU_EQ:     alu_result_o = {31'b0, operand_a_i == operand_b_i};
			default:    alu_result_o = '0;
		endcase
	end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps

module reg_file import riscv_pkg::*;
(
	input  logic     clk,

	input  logic     write_en_i,
	input  reg_idx_t write_addr_i,
	input  word_t    write_data_i,

	input  reg_idx_t read_addr_1_i,
	output word_t    read_data_1_o,

	input  reg_idx_t read_addr_2_i,
	output word_t    read_data_2_o
);

	word_t regs [32];

	always_ff @(posedge clk)
	begin
		if (write_en_i && write_addr_i != 5'd0)
			regs[write_addr_i] <= write_data_i;
	end

	// x0 is hardwired to zero
	assign read_data_1_o = (read_addr_1_i == 5'd0) ? '0 : regs[read_addr_1_i];
	assign read_data_2_o = (read_addr_2_i == 5'd0) ? '0 : regs[read_addr_2_i];

endmodule

// ==== logic/decoder.sv ====
`timescale 1ns/100ps

module decoder import alu_pkg::*, riscv_pkg::*;
(
	input  word_t    instr_i,
	output decoded_t dec_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};
	assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb
	begin
		dec_o           = '0;
		dec_o.rs1       = instr_i[19:15];
		dec_o.rs2       = instr_i[24:20];
		dec_o.rd        = instr_i[11:7];
		dec_o.alu_op    = ALU_ADD;
		dec_o.op_a_sel  = OP_A_REG;
		dec_o.op_b_sel  = OP_B_REG;
		dec_o.wb_sel    = WB_ALU;
		dec_o.imm       = imm_i;

		// Opcode sets the controls, bad funct fields only raise illegal
		case (opcode)
			OPCODE_OP:
			begin
				dec_o.rf_we = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: dec_o.alu_op = ALU_ADD;
					{7'b0100000, 3'b000}: dec_o.alu_op = ALU_SUB;
					{7'b0000000, 3'b001}: dec_o.alu_op = ALU_SLL;
					{7'b0000000, 3'b010}: dec_o.alu_op = ALU_SLT;
					{7'b0000000, 3'b100}: dec_o.alu_op = ALU_XOR;
					{7'b0000000, 3'b101}: dec_o.alu_op = ALU_SRL;
					{7'b0100000, 3'b101}: dec_o.alu_op = ALU_SRA;
					{7'b0000000, 3'b110}: dec_o.alu_op = ALU_OR;
					{7'b0000000, 3'b111}: dec_o.alu_op = ALU_AND;
					default:              dec_o.illegal = 1'b1;
				endcase
			end
			OPCODE_OP_IMM:
			begin
				dec_o.rf_we    = 1'b1;
				dec_o.op_b_sel = OP_B_IMM;
				case (funct3)
					3'b000:  dec_o.alu_op = ALU_ADD;
					3'b100:  dec_o.alu_op = ALU_XOR;
					3'b110:  dec_o.alu_op = ALU_OR;
					3'b111:  dec_o.alu_op = ALU_AND;
					default: dec_o.illegal = 1'b1;
				endcase
			end
			OPCODE_LUI:
			begin
				dec_o.rf_we    = 1'b1;
				dec_o.alu_op   = ALU_PASS_B;
				dec_o.op_a_sel = OP_A_ZERO;
				dec_o.op_b_sel = OP_B_IMM;
				dec_o.imm      = imm_u;
			end
			OPCODE_LOAD:
			begin
				dec_o.rf_we    = 1'b1;
				dec_o.lsu_re   = 1'b1;
				dec_o.op_b_sel = OP_B_IMM;
				dec_o.wb_sel   = WB_LSU;
				dec_o.illegal  = (funct3 != 3'b010);
			end
			OPCODE_STORE:
			begin
				dec_o.lsu_we   = 1'b1;
				dec_o.op_b_sel = OP_B_IMM;
				dec_o.imm      = imm_s;
				dec_o.illegal  = (funct3 != 3'b010);
			end
			OPCODE_BRANCH:
			begin
				dec_o.branch    = 1'b1;
				dec_o.branch_ne = funct3[0];
				dec_o.alu_op    = ALU_EQ;
				dec_o.imm       = imm_b;
				dec_o.illegal   = (funct3[2:1] != 2'b00);
			end
			OPCODE_JAL:
			begin
				dec_o.rf_we  = 1'b1;
				dec_o.jump   = 1'b1;
				dec_o.wb_sel = WB_PC4;
				dec_o.imm    = imm_j;
			end
			default: dec_o.illegal = 1'b1;
		endcase
	end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage import riscv_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n_i,

	input  addr_t target_addr_i,
	input  logic  take_target_i,
	input  logic  is_mem_i,
	input  logic  lsu_done_i,

	output word_t instr_o,
	output addr_t pc_o,
	output logic  exec_o,
	output logic  mem_wait_o,
	output logic  retire_o,

	// Instruction memory port
	output logic  imem_valid_o,
	input  logic  imem_ready_i,
	output addr_t imem_addr_o,
	input  word_t imem_rdata_i
);

	typedef enum logic [1:0] {S_FETCH, S_EXEC, S_WAIT} state_e;

	state_e state_q;
	addr_t  pc_q;
	word_t  instr_q;
	logic   imem_valid_q;
	logic   fetch_done;

	assign fetch_done = (state_q == S_FETCH) && imem_valid_q && imem_ready_i;

	assign exec_o     = (state_q == S_EXEC);
	assign mem_wait_o = (state_q == S_WAIT);
	assign retire_o   = (exec_o && !is_mem_i) || (mem_wait_o && lsu_done_i);

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			state_q      <= S_FETCH;
			pc_q         <= BOOT_ADDRESS;
			imem_valid_q <= 1'b0;
		end
		else if (retire_o)
		begin
			state_q      <= S_FETCH;
			pc_q         <= take_target_i ? target_addr_i : pc_q + 32'd4;
			imem_valid_q <= 1'b1;
		end
		else
		begin
			case (state_q)
				S_FETCH:
				begin
					if (fetch_done)
						state_q <= S_EXEC;
					imem_valid_q <= !fetch_done;
				end
				// Memory instruction, hand over to the LSU
				S_EXEC:  state_q <= S_WAIT;
				S_WAIT:  state_q <= S_WAIT;
				default: state_q <= S_FETCH;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (fetch_done)
			instr_q <= imem_rdata_i;
	end

	assign instr_o      = instr_q;
	assign pc_o         = pc_q;
	assign imem_valid_o = imem_valid_q;
	assign imem_addr_o  = pc_q;

endmodule

// ==== logic/lsu.sv ====
`timescale 1ns/100ps

module lsu import riscv_pkg::*;
(
	lsu_if.unit        lsu,

	// Data memory port
	output logic       dmem_valid_o,
	input  logic       dmem_ready_i,
	output addr_t      dmem_addr_o,
	output word_t      dmem_wdata_o,
	output logic [3:0] dmem_we_o,
	input  word_t      dmem_rdata_i
);

	logic req;

	assign req = lsu.re | lsu.we;

	assign dmem_valid_o = req;
	assign dmem_addr_o  = lsu.addr;
	assign dmem_wdata_o = lsu.wdata;

	// Word accesses only, all byte lanes or none
	assign dmem_we_o = {4{lsu.we}};

	assign lsu.rdata = dmem_rdata_i;
	assign lsu.done  = req & dmem_ready_i;

endmodule

// ==== logic/riscv_core.sv ====
`timescale 1ns/100ps

module riscv_core import alu_pkg::*, riscv_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,

	// Instruction memory
	output logic       imem_valid_o,
	input  logic       imem_ready_i,
	output addr_t      imem_addr_o,
	input  word_t      imem_rdata_i,

	// Data memory
	output logic       dmem_valid_o,
	input  logic       dmem_ready_i,
	output addr_t      dmem_addr_o,
	output word_t      dmem_wdata_o,
	output logic [3:0] dmem_we_o,
	input  word_t      dmem_rdata_i
);

	word_t    instr;
	addr_t    pc;
	decoded_t dec;
	logic     op_valid;

	word_t    alu_operand_a;
	word_t    alu_operand_b;
	word_t    alu_result;

	word_t    rf_read_data_1;
	word_t    rf_read_data_2;
	word_t    rf_write_data;
	logic     rf_write_en;

	addr_t    target_addr;
	logic     branch_taken;
	logic     take_target;
	logic     is_mem;
	logic     exec;
	logic     mem_wait;
	logic     retire;

	lsu_if lsu_bus ();

	decoder decoder
	(
		.instr_i (instr),
		.dec_o   (dec)
	);

	// Illegal encodings retire as no-ops
	assign op_valid = !dec.illegal;

	always_comb
	begin
		case (dec.op_a_sel)
			OP_A_REG:  alu_operand_a = rf_read_data_1;
			OP_A_ZERO: alu_operand_a = '0;
			OP_A_PC:   alu_operand_a = pc;
			default:   alu_operand_a = rf_read_data_1;
		endcase

		case (dec.op_b_sel)
			OP_B_REG: alu_operand_b = rf_read_data_2;
			OP_B_IMM: alu_operand_b = dec.imm;
			default:  alu_operand_b = rf_read_data_2;
		endcase

		case (dec.wb_sel)
			WB_ALU:  rf_write_data = alu_result;
			WB_LSU:  rf_write_data = lsu_bus.rdata;
			WB_PC4:  rf_write_data = pc + 32'd4;
			default: rf_write_data = alu_result;
		endcase
	end

	alu alu
	(
		.alu_op_i     (dec.alu_op),
		.operand_a_i  (alu_operand_a),
		.operand_b_i  (alu_operand_b),
		.alu_result_o (alu_result)
	);

	assign rf_write_en = dec.rf_we & op_valid & retire;

	reg_file reg_file
	(
		.clk           (clk),
		.write_en_i    (rf_write_en),
		.write_addr_i  (dec.rd),
		.write_data_i  (rf_write_data),
		.read_addr_1_i (dec.rs1),
		.read_data_1_o (rf_read_data_1),
		.read_addr_2_i (dec.rs2),
		.read_data_2_o (rf_read_data_2)
	);

	// Branch and JAL target
	assign target_addr  = pc + dec.imm;
	assign branch_taken = dec.branch & (alu_result[0] ^ dec.branch_ne);
	assign take_target  = exec & op_valid & (dec.jump | branch_taken);
	assign is_mem       = (dec.lsu_re | dec.lsu_we) & op_valid;

	fetch_stage fetch_stage
	(
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.target_addr_i (target_addr),
		.take_target_i (take_target),
		.is_mem_i      (is_mem),
		.lsu_done_i    (lsu_bus.done),
		.instr_o       (instr),
		.pc_o          (pc),
		.exec_o        (exec),
		.mem_wait_o    (mem_wait),
		.retire_o      (retire),
		.imem_valid_o  (imem_valid_o),
		.imem_ready_i  (imem_ready_i),
		.imem_addr_o   (imem_addr_o),
		.imem_rdata_i  (imem_rdata_i)
	);

	assign lsu_bus.re    = mem_wait & dec.lsu_re;
	assign lsu_bus.we    = mem_wait & dec.lsu_we;
	assign lsu_bus.addr  = alu_result;
	assign lsu_bus.wdata = rf_read_data_2;

	lsu lsu
	(
		.lsu          (lsu_bus.unit),
		.dmem_valid_o (dmem_valid_o),
		.dmem_ready_i (dmem_ready_i),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_rdata_i (dmem_rdata_i)
	);

endmodule

// ==== verification/riscv_core_assertions.sv ====
`timescale 1ns/100ps

module riscv_core_assertions import riscv_pkg::*;
(
	input logic  clk,
	input logic  rst_n_i,
	input logic  imem_valid_i,
	input logic  imem_ready_i,
	input addr_t imem_addr_i,
	input logic  dmem_valid_i,
	input logic  dmem_ready_i,
	input addr_t dmem_addr_i,
	input word_t dmem_wdata_i
);

	// Requests hold until accepted
	imem_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		imem_valid_i && !imem_ready_i |=> imem_valid_i && $stable(imem_addr_i))
		else $error("imem request dropped or changed before ready");

	dmem_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		dmem_valid_i && !dmem_ready_i |=>
		dmem_valid_i && $stable(dmem_addr_i) && $stable(dmem_wdata_i))
		else $error("dmem request dropped or changed before ready");

	one_port: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(imem_valid_i && dmem_valid_i))
		else $error("imem and dmem requests active together");

	// Both ports idle while in reset
	reset_idle: assert property (@(posedge clk)
		!rst_n_i |=> !imem_valid_i && !dmem_valid_i)
		else $error("memory request active during reset");

endmodule

bind riscv_core riscv_core_assertions riscv_core_assertions_i
(
	.clk          (clk),
	.rst_n_i      (rst_n_i),
	.imem_valid_i (imem_valid_o),
	.imem_ready_i (imem_ready_i),
	.imem_addr_i  (imem_addr_o),
	.dmem_valid_i (dmem_valid_o),
	.dmem_ready_i (dmem_ready_i),
	.dmem_addr_i  (dmem_addr_o),
	.dmem_wdata_i (dmem_wdata_o)
);

// ==== verification/tb_riscv_core.sv ====
`timescale 1ns/100ps

module tb_riscv_core import riscv_pkg::*; ();

	logic       clk;
	logic       rst_n_i;
	logic       imem_valid_o;
	logic       imem_ready_i;
	addr_t      imem_addr_o;
	word_t      imem_rdata_i;
	logic       dmem_valid_o;
	logic       dmem_ready_i;
	addr_t      dmem_addr_o;
	word_t      dmem_wdata_o;
	logic [3:0] dmem_we_o;
	word_t      dmem_rdata_i;

	integer     seed;
	word_t      prog [64];
	word_t      dmem [128];
	word_t      model_mem [128];
	addr_t      exp_fetch [$];
	addr_t      exp_daddr [$];
	logic [3:0] exp_dwe [$];
	word_t      exp_dwdata [$];
	bit         exp_dx0 [$];
	int         fetch_idx, data_idx, imem_wait, dmem_wait, cycles, total_errs;
	int         seq_checks, seq_errs, ctrl_checks, ctrl_errs, wdata_checks, wdata_errs;
	int         addr_checks, addr_errs, x0_checks, x0_errs;
	bit         timed_out;

	riscv_core dut_i
	(
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.imem_valid_o (imem_valid_o),
		.imem_ready_i (imem_ready_i),
		.imem_addr_o  (imem_addr_o),
		.imem_rdata_i (imem_rdata_i),
		.dmem_valid_o (dmem_valid_o),
		.dmem_ready_i (dmem_ready_i),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_rdata_i (dmem_rdata_i)
	);

	always #2 clk = ~clk;

	function automatic int random_below(input int n);
		random_below = int'($unsigned($random(seed)) % n);
	endfunction

	function automatic word_t enc_r(input word_t f7, input word_t rs2, input word_t rs1,
		input word_t f3, input word_t rd);
		enc_r = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPCODE_OP};
	endfunction

	function automatic word_t enc_i(input word_t imm, input word_t rs1, input word_t f3,
		input word_t rd, input word_t op);
		enc_i = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic word_t enc_s(input word_t imm, input word_t rs2, input word_t rs1);
		enc_s = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPCODE_STORE};
	endfunction

	function automatic word_t enc_b(input word_t imm, input word_t rs2, input word_t rs1,
		input word_t f3);
		enc_b = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			OPCODE_BRANCH};
	endfunction

	function automatic word_t enc_j(input word_t imm, input word_t rd);
		enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPCODE_JAL};
	endfunction

	task automatic build_program();
		int i;
		int sel;
		word_t rd, rs1, rs2, off;
		for (i = 0; i < 7; i++)
		begin
			prog[2 * i] = {$random(seed)} & 32'hffff_f000 | word_t'((i + 1) << 7) | 32'h37;
			prog[2 * i + 1] = enc_i($random(seed), i + 1, 0, i + 1, OPCODE_OP_IMM);
		end
		for (i = 14; i < 55; i++)
		begin
			rd = random_below(8);
			rs1 = random_below(8);
			rs2 = random_below(8);
			off = word_t'((random_below(3) + 1) * 4);
			case (random_below(10))
				0, 1, 2:
				case (random_below(9))
					0: prog[i] = enc_r(0, rs2, rs1, 0, rd);
					1: prog[i] = enc_r(32'h20, rs2, rs1, 0, rd);
					2: prog[i] = enc_r(0, rs2, rs1, 1, rd);
					3: prog[i] = enc_r(0, rs2, rs1, 2, rd);
					4: prog[i] = enc_r(0, rs2, rs1, 4, rd);
					5: prog[i] = enc_r(0, rs2, rs1, 5, rd);
					6: prog[i] = enc_r(32'h20, rs2, rs1, 5, rd);
					7: prog[i] = enc_r(0, rs2, rs1, 6, rd);
					default: prog[i] = enc_r(0, rs2, rs1, 7, rd);
				endcase
				3: prog[i] = enc_i($random(seed), rs1, 0, rd, OPCODE_OP_IMM);
				4:
				begin
					// XORI, ORI or ANDI
					sel = random_below(3);
					prog[i] = enc_i($random(seed), rs1, (sel == 0) ? 4 : (sel == 1) ? 6 : 7,
						rd, OPCODE_OP_IMM);
				end
				5: prog[i] = ({$random(seed)} & 32'hffff_f000) | (rd << 7) | 32'h37;
				6: prog[i] = enc_i(word_t'(random_below(64) * 4), rs1, 2, rd, OPCODE_LOAD);
				7: prog[i] = enc_s(word_t'(random_below(64) * 4), rs2, rs1);
				8: prog[i] = enc_b(off, rs2, rs1, random_below(2));
				default: prog[i] = enc_j(off, rd);
			endcase
		end
		// Dump x0..x7 and spin on a JAL to itself
		for (i = 0; i < 8; i++)
			prog[55 + i] = enc_s(word_t'(256 + 4 * i), i, 0);
		prog[63] = enc_j(0, 0);
	endtask

	task automatic run_model();
		word_t r [32];
		addr_t pc, npc, daddr;
		word_t ins, a, b, res, imm_i;
		logic [2:0] f3;
		bit wr, finished;
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		pc = BOOT_ADDRESS;
		finished = 0;
		while (!finished)
		begin
			exp_fetch.push_back(pc);
			if (pc == 32'd252)
				finished = 1;
			else
			begin
				ins = prog[pc[7:2]];
				f3 = ins[14:12];
				a = r[ins[19:15]];
				b = r[ins[24:20]];
				imm_i = {{20{ins[31]}}, ins[31:20]};
				res = '0;
				wr = 1;
				npc = pc + 32'd4;
				case (ins[6:0])
					OPCODE_OP:
					case (f3)
						3'd0: res = ins[30] ? a - b : a + b;
						3'd1: res = a << b[4:0];
						3'd2: res = {31'b0, $signed(a) < $signed(b)};
						3'd4: res = a ^ b;
						3'd5: res = ins[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
						3'd6: res = a | b;
						default: res = a & b;
					endcase
					OPCODE_OP_IMM:
					case (f3)
						3'd0: res = a + imm_i;
						3'd4: res = a ^ imm_i;
						3'd6: res = a | imm_i;
						default: res = a & imm_i;
					endcase
					OPCODE_LUI: res = {ins[31:12], 12'b0};
					OPCODE_LOAD:
					begin
						daddr = a + imm_i;
						exp_daddr.push_back(daddr);
						exp_dwe.push_back(4'h0);
						exp_dwdata.push_back('0);
						exp_dx0.push_back(1'b0);
						res = model_mem[daddr[8:2]];
					end
					OPCODE_STORE:
					begin
						wr = 0;
						daddr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
						exp_daddr.push_back(daddr);
						exp_dwe.push_back(4'hf);
						exp_dwdata.push_back(b);
						exp_dx0.push_back(ins[24:20] == 5'd0);
						model_mem[daddr[8:2]] = b;
					end
					OPCODE_BRANCH:
					begin
						wr = 0;
						if ((a == b) != f3[0])
							npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
					end
					default:
					begin
						res = pc + 32'd4;
						npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
					end
				endcase
				if (wr && ins[11:7] != 5'd0)
					r[ins[11:7]] = res;
				pc = npc;
			end
		end
	endtask

	// Memory responders with 0 to 3 wait cycles per transfer
	initial
	begin
		forever
		begin
			@(posedge clk);
			#0.5;
			if (imem_ready_i)
			begin
				imem_ready_i = 1'b0;
				imem_wait = random_below(4);
			end
			else if (imem_valid_o)
			begin
				if (imem_wait == 0)
				begin
					imem_ready_i = 1'b1;
					imem_rdata_i = prog[imem_addr_o[7:2]];
				end
				else
					imem_wait--;
			end
			if (dmem_ready_i)
			begin
				dmem_ready_i = 1'b0;
				dmem_wait = random_below(4);
			end
			else if (dmem_valid_o)
			begin
				if (dmem_wait == 0)
				begin
					dmem_ready_i = 1'b1;
					dmem_rdata_i = dmem[dmem_addr_o[8:2]];
					if (dmem_we_o != 4'h0)
						dmem[dmem_addr_o[8:2]] = dmem_wdata_o;
				end
				else
					dmem_wait--;
			end
		end
	end

	task automatic check_fetch();
		addr_t exp;
		exp = exp_fetch[fetch_idx];
		if (fetch_idx == 0 || exp == exp_fetch[fetch_idx - 1] + 32'd4)
		begin
			seq_checks++;
			assert (imem_addr_o == exp)
			else
			begin
				$display("[FAIL] imem_addr_o expected %h actual %h", exp, imem_addr_o);
				seq_errs++;
			end
		end
		else
		begin
			ctrl_checks++;
			assert (imem_addr_o == exp)
			else
			begin
				$display("[FAIL] imem_addr_o expected %h actual %h", exp, imem_addr_o);
				ctrl_errs++;
			end
		end
		fetch_idx++;
	endtask

	task automatic check_data();
		if (data_idx >= exp_daddr.size())
		begin
			$display("Unexpected data access at address %h after the program ended",
				dmem_addr_o);
			addr_errs++;
		end
		else
		begin
			addr_checks++;
			assert (dmem_addr_o == exp_daddr[data_idx] && dmem_we_o == exp_dwe[data_idx])
			else
			begin
				$display("[FAIL] dmem_addr_o/dmem_we_o expected %h/%h actual %h/%h",
					exp_daddr[data_idx], exp_dwe[data_idx], dmem_addr_o, dmem_we_o);
				addr_errs++;
			end
			if (exp_dwe[data_idx] != 4'h0)
			begin
				wdata_checks++;
				assert (dmem_wdata_o == exp_dwdata[data_idx])
				else
				begin
					$display("[FAIL] dmem_wdata_o expected %h actual %h",
						exp_dwdata[data_idx], dmem_wdata_o);
					wdata_errs++;
				end
				if (exp_dx0[data_idx])
				begin
					x0_checks++;
					assert (dmem_wdata_o == 32'h0)
					else
					begin
						$display("[FAIL] dmem_wdata_o x0 store expected %h actual %h",
							32'h0, dmem_wdata_o);
						x0_errs++;
					end
				end
			end
			data_idx++;
		end
	endtask

	// Sampled mid-cycle before the transfer edge
	always @(negedge clk)
	begin
		if (rst_n_i && imem_valid_o && imem_ready_i && fetch_idx < exp_fetch.size())
			check_fetch();
		if (rst_n_i && dmem_valid_o && dmem_ready_i)
			check_data();
	end

	task automatic report_line(input string name, input int checks, input int errs);
		$display("%s: %0d checks, %0d errors", name, checks, errs);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		imem_ready_i = 1'b0;
		imem_rdata_i = '0;
		dmem_ready_i = 1'b0;
		dmem_rdata_i = '0;
		seed = 32'h7df0;
		for (int i = 0; i < 128; i++)
		begin
			dmem[i] = $random(seed);
			model_mem[i] = dmem[i];
		end
		build_program();
		run_model();
		repeat (2) @(posedge clk);
		#0.5 rst_n_i = 1'b1;

		cycles = 0;
		timed_out = 0;
		while ((fetch_idx < exp_fetch.size() || data_idx < exp_daddr.size()) && !timed_out)
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= 2000)
				timed_out = 1;
		end
		if (timed_out)
			$display("Timeout: the program did not finish within 2000 cycles");

		report_line("Boot and sequential fetch", seq_checks, seq_errs);
		report_line("Branch and JAL fetch targets", ctrl_checks, ctrl_errs);
		report_line("ALU, LUI and load results in store data", wdata_checks, wdata_errs);
		report_line("Data address and byte enables", addr_checks, addr_errs);
		report_line("Stores of x0 write zero", x0_checks, x0_errs);
		total_errs = seq_errs + ctrl_errs + wdata_errs + addr_errs + x0_errs + int'(timed_out);
		report_line("Transfer sequence under random delays", fetch_idx + data_idx, total_errs);
		$display("Total checks %0d, errors %0d", seq_checks + ctrl_checks + wdata_checks
			+ addr_checks + x0_checks, total_errs);
		if (total_errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/alu_pkg.sv
logic/riscv_pkg.sv
logic/lsu_if.sv
logic/alu.sv
logic/reg_file.sv
logic/decoder.sv
logic/fetch_stage.sv
logic/lsu.sv
logic/riscv_core.sv
verification/riscv_core_assertions.sv
verification/tb_riscv_core.sv

// ==== Makefile ====
TOP = tb_riscv_core

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "\*\*\* PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
